// ==== hdl/cal_pkg.sv ====
// Calibration path shared definitions
// Sample, gain and calibration types, sample stream and AXI4-Lite
// request/response structs, plus the register map of the decoder
`default_nettype none

package cal_pkg;

  ////////////////////////////////////////////////////
  // Channel and data widths
  ////////////////////////////////////////////////////

  localparam int unsigned NCH    = 2;
  localparam int unsigned SMP_W  = 14;
  localparam int unsigned GAIN_W = 16;
  localparam int unsigned AXI_AW = 8;
  localparam int unsigned AXI_DW = 32;

  typedef logic signed [SMP_W-1:0]  sample_t;
  typedef logic signed [GAIN_W-1:0] gain_t;

  // One channel of linear calibration
  typedef struct packed {
    gain_t   gain;
    sample_t offset;
  } cal_cfg_t;

  // Free running sample stream, no ready
  typedef struct packed {
    logic    valid;
    sample_t data;
  } smp_stream_t;

  ////////////////////////////////////////////////////
  // AXI4-Lite
  ////////////////////////////////////////////////////

  // Master driven side
  typedef struct packed {
    logic              awvalid;
    logic [AXI_AW-1:0] awaddr;
    logic              wvalid;
    logic [AXI_DW-1:0] wdata;
    logic              bready;
    logic              arvalid;
    logic [AXI_AW-1:0] araddr;
    logic              rready;
  } axil_req_t;

  // Slave driven side
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // Register map, per channel gain at +8*ch, offset at +8*ch+4
  localparam logic [AXI_AW-1:0] REG_LOOP    = 8'h00;
  localparam logic [AXI_AW-1:0] REG_ADC_CAL = 8'h10;
  localparam logic [AXI_AW-1:0] REG_DAC_CAL = 8'h20;

  // Unity gain for 13 fractional bits
  localparam gain_t GAIN_RESET = 16'h2000;

endpackage : cal_pkg

`default_nettype wire

// ==== hdl/cal_reg_decode.sv ====
// AXI4-Lite register slave for the calibration path
// Holds ADC and DAC gain/offset per channel and the loopback selects,
// single outstanding write and read, SLVERR on unmapped addresses
`timescale 1ns/1ps
`default_nettype none

module cal_reg_decode
  import cal_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 top_rst,
  input  axil_req_t            axil_req_i,
  output axil_rsp_t            axil_rsp_o,
  output cal_cfg_t [NCH-1:0]   adc_cfg_o,
  output cal_cfg_t [NCH-1:0]   dac_cfg_o,
  output logic     [NCH-1:0]   loop_o
);

  // Handshake state
  logic              awready_q;
  logic              bvalid_q;
  logic [1:0]        bresp_q;
  logic              arready_q;
  logic              rvalid_q;
  logic [AXI_DW-1:0] rdata_q;
  logic [1:0]        rresp_q;

  // Configuration registers
  cal_cfg_t [NCH-1:0] adc_cfg_q;
  cal_cfg_t [NCH-1:0] dac_cfg_q;
  logic     [NCH-1:0] loop_q;

  logic              wr_hs;
  logic              rd_hs;
  logic              wr_hit;
  logic              rd_hit;
  logic [AXI_DW-1:0] rd_data;

  // Gain register address of one channel, offset sits 4 above
  function automatic logic [AXI_AW-1:0] gain_addr(input logic [AXI_AW-1:0] base,
                                                   input int ch);
    return base + AXI_AW'(8 * ch);
  endfunction

  assign wr_hs = awready_q & axil_req_i.awvalid & axil_req_i.wvalid;
  assign rd_hs = arready_q & axil_req_i.arvalid;

  ////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////

  always_comb begin
    wr_hit  = (axil_req_i.awaddr == REG_LOOP);
    rd_hit  = (axil_req_i.araddr == REG_LOOP);
    rd_data = '0;
    if (axil_req_i.araddr == REG_LOOP) rd_data[NCH-1:0] = loop_q;
    for (int ch = 0; ch < NCH; ch++) begin
      // Writes
      if (axil_req_i.awaddr == gain_addr(REG_ADC_CAL, ch) ||
          axil_req_i.awaddr == gain_addr(REG_ADC_CAL, ch) + 8'd4 ||
          axil_req_i.awaddr == gain_addr(REG_DAC_CAL, ch) ||
          axil_req_i.awaddr == gain_addr(REG_DAC_CAL, ch) + 8'd4) begin
        wr_hit = 1'b1;
      end
      // Reads, sign extended to bus width
      if (axil_req_i.araddr == gain_addr(REG_ADC_CAL, ch)) begin
        rd_hit  = 1'b1;
        rd_data = {{(AXI_DW-GAIN_W){adc_cfg_q[ch].gain[GAIN_W-1]}}, adc_cfg_q[ch].gain};
      end
      if (axil_req_i.araddr == gain_addr(REG_ADC_CAL, ch) + 8'd4) begin
        rd_hit  = 1'b1;
        rd_data = {{(AXI_DW-SMP_W){adc_cfg_q[ch].offset[SMP_W-1]}}, adc_cfg_q[ch].offset};
      end
      if (axil_req_i.araddr == gain_addr(REG_DAC_CAL, ch)) begin
        rd_hit  = 1'b1;
        rd_data = {{(AXI_DW-GAIN_W){dac_cfg_q[ch].gain[GAIN_W-1]}}, dac_cfg_q[ch].gain};
      end
      if (axil_req_i.araddr == gain_addr(REG_DAC_CAL, ch) + 8'd4) begin
        rd_hit  = 1'b1;
        rd_data = {{(AXI_DW-SMP_W){dac_cfg_q[ch].offset[SMP_W-1]}}, dac_cfg_q[ch].offset};
      end
    end
  end

  ////////////////////////////////////////////////////
  // Write channel and registers
  ////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= RESP_OKAY;
      loop_q    <= '0;
      for (int ch = 0; ch < NCH; ch++) begin
        adc_cfg_q[ch] <= '{gain: GAIN_RESET, offset: '0};
        dac_cfg_q[ch] <= '{gain: GAIN_RESET, offset: '0};
      end
    end else begin
      // One cycle pulse, address and data together
      awready_q <= axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q & ~awready_q;
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        if (axil_req_i.awaddr == REG_LOOP) loop_q <= axil_req_i.wdata[NCH-1:0];
        for (int ch = 0; ch < NCH; ch++) begin
          if (axil_req_i.awaddr == gain_addr(REG_ADC_CAL, ch))
            adc_cfg_q[ch].gain <= gain_t'(axil_req_i.wdata[GAIN_W-1:0]);
          if (axil_req_i.awaddr == gain_addr(REG_ADC_CAL, ch) + 8'd4)
            adc_cfg_q[ch].offset <= sample_t'(axil_req_i.wdata[SMP_W-1:0]);
          if (axil_req_i.awaddr == gain_addr(REG_DAC_CAL, ch))
            dac_cfg_q[ch].gain <= gain_t'(axil_req_i.wdata[GAIN_W-1:0]);
          if (axil_req_i.awaddr == gain_addr(REG_DAC_CAL, ch) + 8'd4)
            dac_cfg_q[ch].offset <= sample_t'(axil_req_i.wdata[SMP_W-1:0]);
        end
      end else if (bvalid_q && axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rdata_q   <= '0;
      rresp_q   <= RESP_OKAY;
    end else begin
      arready_q <= axil_req_i.arvalid & ~rvalid_q & ~arready_q;
      if (rd_hs) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_data;
        rresp_q  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (rvalid_q && axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_comb begin
    axil_rsp_o.awready = awready_q;
    axil_rsp_o.wready  = awready_q;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = arready_q;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  assign adc_cfg_o = adc_cfg_q;
  assign dac_cfg_o = dac_cfg_q;
  assign loop_o    = loop_q;

  // Responses wait for the master
  a_bvalid_hold : assert property (@(posedge adc_clk) disable iff (top_rst)
    bvalid_q && !axil_req_i.bready |=> bvalid_q);
  a_rdata_stable : assert property (@(posedge adc_clk) disable iff (top_rst)
    rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rdata_q));

endmodule : cal_reg_decode

`default_nettype wire

// ==== hdl/adc_front.sv ====
// ADC front end
// Registers raw inverted offset-binary codes, turns them into signed
// samples and selects the DAC loopback stream per channel
`timescale 1ns/1ps
`default_nettype none

module adc_front
  import cal_pkg::*;
(
  input  logic                          adc_clk,
  input  logic                          top_rst,
  input  logic        [NCH-1:0][SMP_W-1:0] adc_dat_i,
  input  logic        [NCH-1:0]         loop_i,
  input  smp_stream_t [NCH-1:0]         dac_cal_i,
  output smp_stream_t [NCH-1:0]         smp_o
);

  sample_t [NCH-1:0] smp_q;
  logic              vld_q;

  // Input register, MSB kept and the rest inverted
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < NCH; ch++) begin
      smp_q[ch] <= {adc_dat_i[ch][SMP_W-1], ~adc_dat_i[ch][SMP_W-2:0]};
    end
  end

  // Valid from the first cycle out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) vld_q <= 1'b0;
    else         vld_q <= 1'b1;
  end

  // Digital loopback multiplexer
  always_comb begin
    for (int ch = 0; ch < NCH; ch++) begin
      smp_o[ch] = loop_i[ch] ? dac_cal_i[ch] : '{valid: vld_q, data: smp_q[ch]};
    end
  end

endmodule : adc_front

`default_nettype wire

// ==== hdl/cal_linear.sv ====
// Linear calibration of one sample stream
// Stage one multiplies by the gain, stage two scales back by FRAC_W,
// adds the offset and saturates to the sample range
`timescale 1ns/1ps
`default_nettype none

module cal_linear
  import cal_pkg::*;
#(
  parameter int unsigned FRAC_W = 13
)(
  input  logic        adc_clk,
  input  logic        top_rst,
  input  cal_cfg_t    cfg_i,
  input  smp_stream_t smp_i,
  output smp_stream_t smp_o
);

  localparam int unsigned PROD_W  = SMP_W + GAIN_W;
  localparam int signed   SMP_MAX = 2 ** (SMP_W - 1) - 1;
  localparam int signed   SMP_MIN = -(2 ** (SMP_W - 1));

  logic signed [PROD_W-1:0] prod_q;
  logic signed [PROD_W:0]   sum;
  sample_t                  sat;
  logic                     vld1_q;
  logic                     vld2_q;
  sample_t                  dat2_q;

  // Stage one, full width product
  always_ff @(posedge adc_clk) begin
    prod_q <= smp_i.data * cfg_i.gain;
  end

  // Floor shift plus offset, one spare bit for the sum
  always_comb begin
    sum = ((PROD_W + 1)'(prod_q) >>> FRAC_W) + (PROD_W + 1)'(cfg_i.offset);
    if (sum > SMP_MAX)      sat = sample_t'(SMP_MAX);
    else if (sum < SMP_MIN) sat = sample_t'(SMP_MIN);
    else                    sat = sample_t'(sum);
  end

  // Stage two
  always_ff @(posedge adc_clk) begin
    dat2_q <= sat;
  end

  // Valid follows the data
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld1_q <= 1'b0;
      vld2_q <= 1'b0;
    end else begin
      vld1_q <= smp_i.valid;
      vld2_q <= vld1_q;
    end
  end

  assign smp_o = '{valid: vld2_q, data: dat2_q};

  a_two_cycles : assert property (@(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst, 1) && !$past(top_rst, 2) |-> smp_o.valid == $past(smp_i.valid, 2));

endmodule : cal_linear

`default_nettype wire

// ==== hdl/dac_back.sv ====
// DAC back end
// Keeps the latest calibrated sample per channel in inverted offset
// binary and interleaves both onto one bus with a toggling select
`timescale 1ns/1ps
`default_nettype none

module dac_back
  import cal_pkg::*;
(
  input  logic                  adc_clk,
  input  logic                  top_rst,
  input  smp_stream_t [NCH-1:0] dac_cal_i,
  output logic        [SMP_W-1:0] dac_dat_o,
  output logic                  dac_sel_o
);

  logic [NCH-1:0][SMP_W-1:0] hold_q;
  logic [SMP_W-1:0]          dat_q;
  logic                      sel_q;

  // Hold last valid sample, already formatted
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      hold_q <= '0;
    end else begin
      for (int ch = 0; ch < NCH; ch++) begin
        if (dac_cal_i[ch].valid)
          hold_q[ch] <= {dac_cal_i[ch].data[SMP_W-1], ~dac_cal_i[ch].data[SMP_W-2:0]};
      end
    end
  end

  ////////////////////////////////////////////////////
  // Interleave, ch0 with select high
  ////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sel_q <= 1'b0;
      dat_q <= '0;
    end else begin
      sel_q <= ~sel_q;
      // Next select is ~sel_q
      dat_q <= sel_q ? hold_q[1] : hold_q[0];
    end
  end

  assign dac_dat_o = dat_q;
  assign dac_sel_o = sel_q;

  a_sel_toggle : assert property (@(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> dac_sel_o != $past(dac_sel_o));

endmodule : dac_back

`default_nettype wire

// ==== hdl/cal_top.sv ====
// Analog conditioning path top level
// AXI4-Lite register decoder, ADC front end, ADC and DAC linear
// calibration per channel and the interleaved DAC back end
`timescale 1ns/1ps
`default_nettype none

module cal_top
  import cal_pkg::*;
#(
  parameter int unsigned FRAC_W = 13
)(
  input  logic                             adc_clk,
  input  logic                             top_rst,
  // Register bus
  input  axil_req_t                        s_axil_req_i,
  output axil_rsp_t                        s_axil_rsp_o,
  // ADC and generator streams
  input  logic        [NCH-1:0][SMP_W-1:0] adc_dat_i,
  input  smp_stream_t [NCH-1:0]            gen_i,
  output smp_stream_t [NCH-1:0]            osc_o,
  // DAC pins
  output logic        [SMP_W-1:0]          dac_dat_o,
  output logic                             dac_sel_o
);

  cal_cfg_t    [NCH-1:0] adc_cfg;
  cal_cfg_t    [NCH-1:0] dac_cfg;
  logic        [NCH-1:0] loop;
  smp_stream_t [NCH-1:0] adc_smp;
  // Calibrated generator, goes to loopback and DAC
  smp_stream_t [NCH-1:0] dac_cal;

  ////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////

  cal_reg_decode u_regs (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .axil_req_i (s_axil_req_i),
    .axil_rsp_o (s_axil_rsp_o),
    .adc_cfg_o  (adc_cfg),
    .dac_cfg_o  (dac_cfg),
    .loop_o     (loop)
  );

  ////////////////////////////////////////////////////
  // Acquisition and generation
  ////////////////////////////////////////////////////

  adc_front u_adc (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .loop_i    (loop),
    .dac_cal_i (dac_cal),
    .smp_o     (adc_smp)
  );

  for (genvar ch = 0; ch < NCH; ch++) begin : g_ch
    cal_linear #(.FRAC_W (FRAC_W)) u_adc_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .cfg_i   (adc_cfg[ch]),
      .smp_i   (adc_smp[ch]),
      .smp_o   (osc_o[ch])
    );
    cal_linear #(.FRAC_W (FRAC_W)) u_dac_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .cfg_i   (dac_cfg[ch]),
      .smp_i   (gen_i[ch]),
      .smp_o   (dac_cal[ch])
    );
  end : g_ch

  dac_back u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dac_cal_i (dac_cal),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

endmodule : cal_top

`default_nettype wire

// ==== test/tb_clkgen.sv ====
// Testbench clock and reset source
// Free running clock, reset held for a few cycles at start
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 3
)(
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after an edge like any other input
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule : tb_clkgen

`default_nettype wire

// ==== test/tb_cal_top.sv ====
// Testbench for the calibration path top level
// Register access over AXI4-Lite, ADC conversion and calibration,
// DAC formatting with interleave, and the digital loopback
`timescale 1ns/1ps
`default_nettype none

module tb_cal_top
  import cal_pkg::*;
;

  localparam int FRAC_W = 13;
  localparam int TMO    = 50;

  typedef struct {
    int      due;
    int      ch;
    logic    vld;
    sample_t val;
  } exp_t;

  logic                      clk;
  logic                      rst;
  axil_req_t                 req;
  axil_rsp_t                 rsp;
  logic [NCH-1:0][SMP_W-1:0] adc_dat;
  smp_stream_t [NCH-1:0]     gen;
  smp_stream_t [NCH-1:0]     osc;
  logic [SMP_W-1:0]          dac_dat;
  logic                      dac_sel;

  // Expected osc_o samples, oldest first
  exp_t        exp_q[$];
  exp_t        cur;
  int          cyc;
  string       test_name;
  logic [31:0] lfsr;
  int          err_smp;
  int          err_dac;
  int          err_bus;
  int          err_flag;
  // Current calibration as programmed
  gain_t       agn [NCH];
  sample_t     aof [NCH];
  gain_t       dgn [NCH];
  sample_t     dof [NCH];

  tb_clkgen #(.PERIOD_NS (20), .RST_CYCLES (3)) u_clk (.clk_o (clk), .rst_o (rst));

  cal_top #(.FRAC_W (FRAC_W)) dut (
    .adc_clk      (clk),
    .top_rst      (rst),
    .s_axil_req_i (req),
    .s_axil_rsp_o (rsp),
    .adc_dat_i    (adc_dat),
    .gen_i        (gen),
    .osc_o        (osc),
    .dac_dat_o    (dac_dat),
    .dac_sel_o    (dac_sel)
  );

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////
  // Random bits and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r[i] = lfsr[0];
    end
    return r;
  endfunction

  // Inverted offset binary, MSB kept
  function automatic sample_t adc_code_to_smp(input logic [SMP_W-1:0] raw);
    return sample_t'(raw ^ 14'h1FFF);
  endfunction

  function automatic logic [SMP_W-1:0] smp_to_dac_code(input sample_t s);
    return SMP_W'(s) ^ 14'h1FFF;
  endfunction

  // Floor of x*g / 2**FRAC_W, plus offset, clipped to 14 bits
  function automatic sample_t cal_ref(input sample_t x, input gain_t g, input sample_t off);
    longint p;
    longint q;
    longint unit;
    unit = longint'(1) << FRAC_W;
    p = longint'(x) * longint'(g);
    q = p / unit;
    if (p < 0 && q * unit != p) q = q - 1;
    q = q + longint'(off);
    if (q > 8191) q = 8191;
    else if (q < -8192) q = -8192;
    return sample_t'(q);
  endfunction

  // Register read value, low w bits sign extended
  function automatic logic [AXI_DW-1:0] sext_ref(input logic [AXI_DW-1:0] d, input int w);
    logic [AXI_DW-1:0] m;
    m = (32'h1 << w) - 1;
    return d[w-1] ? (d | ~m) : (d & m);
  endfunction

  function automatic logic [AXI_AW-1:0] cal_addr(input logic [AXI_AW-1:0] base, input int ch,
                                                 input bit is_off);
    return base + AXI_AW'(8 * ch) + (is_off ? 8'd4 : 8'd0);
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_smp(input string name, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      err_smp++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_code(input string name, input logic [SMP_W-1:0] exp,
                            input logic [SMP_W-1:0] act);
    if (act !== exp) begin
      err_dac++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      err_bus++;
      $display("FAIL %s: expected resp %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input logic [AXI_DW-1:0] exp,
                            input logic [AXI_DW-1:0] act);
    if (act !== exp) begin
      err_bus++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic abort_run(input string what);
    $display("ERROR: %s during test %s", what, test_name);
    $display("*** FAILED ***");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Bus and stream drivers
  //////////////////////////////////////////////////

  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic axil_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                            output logic [1:0] resp);
    int n;
    req.awaddr  = addr;
    req.wdata   = data;
    req.awvalid = 1'b1;
    req.wvalid  = 1'b1;
    n = 0;
    do begin
      step();
      n++;
    end while (!rsp.awready && n < TMO);
    if (!rsp.awready) abort_run("write address was never accepted");
    // Data channel accepted together with the address
    check_flag($sformatf("%s wready", test_name), 1'b1, rsp.wready);
    // Handshake on the next edge
    step();
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    n = 0;
    while (!rsp.bvalid && n < TMO) begin
      step();
      n++;
    end
    if (!rsp.bvalid) abort_run("write response never arrived");
    resp = rsp.bresp;
  endtask

  task automatic axil_read(input logic [AXI_AW-1:0] addr, output logic [1:0] resp,
                           output logic [AXI_DW-1:0] data);
    int n;
    req.araddr  = addr;
    req.arvalid = 1'b1;
    n = 0;
    do begin
      step();
      n++;
    end while (!rsp.arready && n < TMO);
    if (!rsp.arready) abort_run("read address was never accepted");
    step();
    req.arvalid = 1'b0;
    n = 0;
    while (!rsp.rvalid && n < TMO) begin
      step();
      n++;
    end
    if (!rsp.rvalid) abort_run("read data never arrived");
    resp = rsp.rresp;
    data = rsp.rdata;
  endtask

  task automatic reg_write_ok(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_resp($sformatf("%s wr %h", test_name, addr), RESP_OKAY, resp);
  endtask

  task automatic reg_read_check(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] exp);
    logic [1:0]        resp;
    logic [AXI_DW-1:0] data;
    axil_read(addr, resp, data);
    check_resp($sformatf("%s rd %h", test_name, addr), RESP_OKAY, resp);
    check_word($sformatf("%s rd %h", test_name, addr), exp, data);
  endtask

  task automatic set_cal(input logic [AXI_AW-1:0] base, input int ch, input gain_t g,
                         input sample_t o);
    reg_write_ok(cal_addr(base, ch, 0), AXI_DW'(g));
    reg_write_ok(cal_addr(base, ch, 1), AXI_DW'(o));
  endtask

  task automatic expect_smp(input int ch, input int lat, input logic vld, input sample_t val);
    exp_t e;
    e.due = cyc + lat;
    e.ch  = ch;
    e.vld = vld;
    e.val = val;
    exp_q.push_back(e);
  endtask

  // Random raw ADC codes, result 3 cycles later
  task automatic stream_adc(input int n);
    logic [SMP_W-1:0] raw;
    for (int i = 0; i < n; i++) begin
      for (int ch = 0; ch < NCH; ch++) begin
        raw = SMP_W'(rand_bits(SMP_W));
        adc_dat[ch] = raw;
        expect_smp(ch, 3, 1'b1, cal_ref(adc_code_to_smp(raw), agn[ch], aof[ch]));
      end
      step();
    end
  endtask

  // Generator through both calibrations, 4 cycles
  task automatic stream_loop(input int n);
    sample_t s;
    logic    v;
    for (int i = 0; i < n; i++) begin
      for (int ch = 0; ch < NCH; ch++) begin
        v = 1'(rand_bits(1));
        s = sample_t'(rand_bits(SMP_W));
        gen[ch].valid = v;
        gen[ch].data  = s;
        expect_smp(ch, 4, v, cal_ref(cal_ref(s, dgn[ch], dof[ch]), agn[ch], aof[ch]));
      end
      step();
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TMO) begin
      step();
      n++;
    end
    if (exp_q.size() != 0) abort_run("expected samples were left unchecked");
  endtask

  // osc_o compare, away from the input drive time
  always @(posedge clk) begin
    #1;
    while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
      cur = exp_q.pop_front();
      check_flag($sformatf("%s osc%0d valid", test_name, cur.ch), cur.vld, osc[cur.ch].valid);
      if (cur.vld)
        check_smp($sformatf("%s osc%0d", test_name, cur.ch), cur.val, osc[cur.ch].data);
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    int                n;
    int                run;
    logic              prev;
    logic [1:0]        resp;
    logic [AXI_DW-1:0] d;
    sample_t           gsmp [NCH];
    logic [SMP_W-1:0]  dexp [NCH];
    req         = '0;
    req.bready  = 1'b1;
    req.rready  = 1'b1;
    adc_dat     = '0;
    gen         = '0;
    lfsr        = 32'hb50bb0cf;
    test_name   = "reset";
    for (int ch = 0; ch < NCH; ch++) begin
      agn[ch] = GAIN_RESET;
      aof[ch] = '0;
    end
    n = 0;
    while (rst !== 1'b0 && n < TMO) begin
      step();
      n++;
    end
    if (rst !== 1'b0) abort_run("reset was never released");
    step();

    // 1 reset values and select toggle
    test_name = "reset_values";
    reg_read_check(REG_LOOP, '0);
    for (int ch = 0; ch < NCH; ch++) begin
      reg_read_check(cal_addr(REG_ADC_CAL, ch, 0), 32'h0000_2000);
      reg_read_check(cal_addr(REG_ADC_CAL, ch, 1), '0);
      reg_read_check(cal_addr(REG_DAC_CAL, ch, 0), 32'h0000_2000);
      reg_read_check(cal_addr(REG_DAC_CAL, ch, 1), '0);
    end
    prev = dac_sel;
    repeat (8) begin
      step();
      check_flag("reset_values dac_sel toggle", ~prev, dac_sel);
      prev = dac_sel;
    end

    // 2 read back and unmapped access
    test_name = "reg_access";
    reg_write_ok(cal_addr(REG_ADC_CAL, 0, 0), 32'h0000_8001);
    reg_read_check(cal_addr(REG_ADC_CAL, 0, 0), 32'hFFFF_8001);
    d = rand_bits(32);
    reg_write_ok(cal_addr(REG_ADC_CAL, 1, 0), d);
    reg_read_check(cal_addr(REG_ADC_CAL, 1, 0), sext_ref(d, GAIN_W));
    d = rand_bits(32);
    reg_write_ok(cal_addr(REG_DAC_CAL, 1, 1), d);
    reg_read_check(cal_addr(REG_DAC_CAL, 1, 1), sext_ref(d, SMP_W));
    d = rand_bits(32);
    reg_write_ok(REG_LOOP, d);
    reg_read_check(REG_LOOP, d & 32'h3);
    // Master stalls, responses wait for it
    req.bready = 1'b0;
    reg_write_ok(REG_LOOP, 32'h2);
    repeat (3) begin
      step();
      check_flag("reg_access bvalid hold", 1'b1, rsp.bvalid);
    end
    req.bready = 1'b1;
    step();
    check_flag("reg_access bvalid release", 1'b0, rsp.bvalid);
    req.rready = 1'b0;
    reg_read_check(REG_LOOP, 32'h2);
    repeat (3) begin
      step();
      check_flag("reg_access rvalid hold", 1'b1, rsp.rvalid);
      check_word("reg_access rdata hold", 32'h2, rsp.rdata);
    end
    req.rready = 1'b1;
    step();
    check_flag("reg_access rvalid release", 1'b0, rsp.rvalid);
    axil_write(8'h44, 32'hDEAD_BEEF, resp);
    check_resp("reg_access unmapped wr", RESP_SLVERR, resp);
    axil_read(8'h44, resp, d);
    check_resp("reg_access unmapped rd", RESP_SLVERR, resp);
    check_word("reg_access unmapped rd", '0, d);
    reg_write_ok(REG_LOOP, '0);
    set_cal(REG_ADC_CAL, 0, GAIN_RESET, '0);
    set_cal(REG_ADC_CAL, 1, GAIN_RESET, '0);
    set_cal(REG_DAC_CAL, 1, GAIN_RESET, '0);

    // 3 unity gain
    test_name = "adc_unity";
    stream_adc(64);
    drain();

    // 4 random calibration, last round saturates hard
    test_name = "adc_cal";
    for (int r = 0; r < 4; r++) begin
      for (int ch = 0; ch < NCH; ch++) begin
        agn[ch] = gain_t'(rand_bits(GAIN_W));
        aof[ch] = sample_t'(rand_bits(SMP_W));
      end
      if (r == 3) begin
        agn[0] = 16'h7FFF;
        aof[0] = 14'h1FFF;
        agn[1] = 16'h8000;
        aof[1] = 14'h2000;
      end
      for (int ch = 0; ch < NCH; ch++) set_cal(REG_ADC_CAL, ch, agn[ch], aof[ch]);
      stream_adc(32);
      drain();
    end

    // 5 DAC formatting and interleave
    test_name = "dac_format";
    for (int ch = 0; ch < NCH; ch++) begin
      dgn[ch]  = gain_t'(rand_bits(GAIN_W));
      dof[ch]  = sample_t'(rand_bits(SMP_W));
      gsmp[ch] = sample_t'(rand_bits(SMP_W));
      set_cal(REG_DAC_CAL, ch, dgn[ch], dof[ch]);
      dexp[ch] = smp_to_dac_code(cal_ref(gsmp[ch], dgn[ch], dof[ch]));
    end
    for (int ch = 0; ch < NCH; ch++) begin
      gen[ch].valid = 1'b1;
      gen[ch].data  = gsmp[ch];
    end
    run = 0;
    n   = 0;
    while (run < 2 && n < TMO) begin
      step();
      n++;
      if (dac_dat === (dac_sel ? dexp[0] : dexp[1])) run++;
      else run = 0;
    end
    if (run < 2) abort_run("DAC output never settled");
    repeat (8) begin
      step();
      check_code($sformatf("dac_format sel=%b", dac_sel), dac_sel ? dexp[0] : dexp[1],
                 dac_dat);
    end

    // 6 loopback through both calibrations
    test_name = "loopback";
    gen = '0;
    for (int ch = 0; ch < NCH; ch++) begin
      agn[ch] = gain_t'(rand_bits(GAIN_W));
      aof[ch] = sample_t'(rand_bits(SMP_W));
      set_cal(REG_ADC_CAL, ch, agn[ch], aof[ch]);
    end
    reg_write_ok(REG_LOOP, 32'h3);
    stream_loop(48);
    drain();

    $display("Errors: samples %0d, dac codes %0d, bus %0d, flags %0d",
             err_smp, err_dac, err_bus, err_flag);
    if (err_smp + err_dac + err_bus + err_flag == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule : tb_cal_top

`default_nettype wire

// ==== verilog.f ====
hdl/cal_pkg.sv
hdl/cal_reg_decode.sv
hdl/adc_front.sv
hdl/cal_linear.sv
hdl/dac_back.sv
hdl/cal_top.sv
test/tb_clkgen.sv
test/tb_cal_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the calibration path testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cal_top \
  -f verilog.f -o tb_cal_top \
  && ./obj_dir/tb_cal_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
